/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		op_reg    = 7'b0110011,
		op_imm    = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111
	} opcode_t;

	// beq shares its funct3 encoding with add
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;
	localparam logic [2:0] f3_word    = 3'b010;
	localparam logic [2:0] f3_beq     = 3'b000;
	localparam logic [6:0] f7_sub     = 7'b0100000;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_link
	} wb_sel_t;

	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t instr;
	} fetch_word_t;

	typedef struct packed {
		logic      valid;
		word_t     pc;
		word_t     rs1_data;
		word_t     rs2_data;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t     imm;
		alu_op_t   alu_op;
		logic      use_imm;
		logic      is_load;
		logic      is_store;
		logic      is_branch;
		logic      is_jal;
		logic      reg_write;
		wb_sel_t   wb_sel;
	} decoded_t;

	typedef struct packed {
		logic      valid;
		word_t     result;
		word_t     store_data;
		reg_addr_t rd;
		logic      is_load;
		logic      is_store;
		logic      reg_write;
		wb_sel_t   wb_sel;
	} mem_stage_t;

	typedef struct packed {
		logic      reg_write;
		reg_addr_t rd;
		word_t     data;
	} wb_t;

endpackage

`default_nettype wire

/* rv_pipe_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rv_pipe_if;
	import rv_pkg::*;

	// load-use hazard seen in decode
	logic stall;
	// taken beq or jal resolved in execute
	logic redirect;
	word_t target;
	// squashes the decode/execute register along with redirect
	logic flush;

	modport fetch_mp (
		input stall,
		input redirect,
		input target
	);

	modport decode_mp (
		output stall,
		input flush
	);

	modport execute_mp (
		output redirect,
		output target,
		output flush
	);

endinterface

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input  logic                clock,
	input  logic                reset,
	rv_pipe_if.fetch_mp         ctrl,
	output rv_pkg::word_t       imem_addr,
	input  rv_pkg::word_t       imem_data,
	output rv_pkg::fetch_word_t fetched
);
	import rv_pkg::*;

	word_t pc;
	word_t next_pc;
	// low until the first word at reset_pc has been requested
	logic  fetch_live;

	// redirect has priority over stall
	always_comb begin
		if (!fetch_live) begin
			next_pc = pc;
		end else if (ctrl.redirect) begin
			next_pc = ctrl.target;
		end else if (ctrl.stall) begin
			next_pc = pc;
		end else begin
			next_pc = pc + word_t'(4);
		end
	end

	// memory sees the next pc, so the word for pc arrives with it
	assign imem_addr = next_pc;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= reset_pc;
			fetch_live <= 1'b0;
		end else begin
			pc <= next_pc;
			fetch_live <= 1'b1;
		end
	end

	// fetch/decode register
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			fetched <= '0;
		end else if (ctrl.redirect) begin
			fetched.valid <= 1'b0;
		end else if (!ctrl.stall) begin
			fetched.valid <= fetch_live;
			fetched.pc <= pc;
			fetched.instr <= imem_data;
		end
	end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic              clock,
	input  logic              reset,
	input  rv_pkg::reg_addr_t ra1,
	input  rv_pkg::reg_addr_t ra2,
	output rv_pkg::word_t     rd1,
	output rv_pkg::word_t     rd2,
	input  rv_pkg::wb_t       wb
);
	import rv_pkg::*;

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.reg_write && (wb.rd != '0)) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// write-through so decode sees a result retiring this cycle
	assign rd1 = (ra1 == '0) ? '0 : (wb.reg_write && (wb.rd == ra1)) ? wb.data : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (wb.reg_write && (wb.rd == ra2)) ? wb.data : regs[ra2];

endmodule

`default_nettype wire

/* decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
	input  logic                clock,
	input  logic                reset,
	rv_pipe_if.decode_mp        ctrl,
	input  rv_pkg::fetch_word_t fetched,
	input  rv_pkg::wb_t         wb,
	output rv_pkg::decoded_t    decoded
);
	import rv_pkg::*;

	word_t     instr;
	reg_addr_t rs1;
	reg_addr_t rs2;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t     rd1;
	word_t     rd2;
	word_t     imm_i;
	word_t     imm_s;
	word_t     imm_b;
	word_t     imm_j;
	decoded_t  next;

	assign instr  = fetched.instr;
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	reg_file u_regs (
		.clock (clock),
		.reset (reset),
		.ra1   (rs1),
		.ra2   (rs2),
		.rd1   (rd1),
		.rd2   (rd2),
		.wb    (wb)
	);

	// unknown encodings fall through with no side effects
	always_comb begin
		next = '0;
		next.valid = fetched.valid;
		next.pc = fetched.pc;
		next.rs1_data = rd1;
		next.rs2_data = rd2;
		next.rs1 = rs1;
		next.rs2 = rs2;
		next.rd = instr[11:7];
		next.alu_op = alu_add;
		next.wb_sel = wb_alu;
		case (instr[6:0])
			op_reg: begin
				next.reg_write = 1'b1;
				case (funct3)
					f3_add_sub: next.alu_op = (funct7 == f7_sub) ? alu_sub : alu_add;
					f3_slt: next.alu_op = alu_slt;
					f3_xor: next.alu_op = alu_xor;
					f3_or: next.alu_op = alu_or;
					f3_and: next.alu_op = alu_and;
					default: next.reg_write = 1'b0;
				endcase
			end
			op_imm: begin
				next.imm = imm_i;
				next.use_imm = 1'b1;
				next.reg_write = (funct3 == f3_add_sub);
			end
			op_load: begin
				next.imm = imm_i;
				next.use_imm = 1'b1;
				next.is_load = (funct3 == f3_word);
				next.reg_write = (funct3 == f3_word);
				next.wb_sel = wb_mem;
			end
			op_store: begin
				next.imm = imm_s;
				next.use_imm = 1'b1;
				next.is_store = (funct3 == f3_word);
			end
			op_branch: begin
				next.imm = imm_b;
				next.is_branch = (funct3 == f3_beq);
			end
			op_jal: begin
				next.imm = imm_j;
				next.is_jal = 1'b1;
				next.reg_write = 1'b1;
				next.wb_sel = wb_link;
			end
			default: ;
		endcase
	end

	// a load still in execute has no data to forward yet
	assign ctrl.stall = fetched.valid && decoded.valid && decoded.is_load &&
		(decoded.rd != '0) && ((decoded.rd == rs1) || (decoded.rd == rs2));

	// decode/execute register
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			decoded <= '0;
		end else if (ctrl.stall || ctrl.flush) begin
			decoded <= '0;
		end else begin
			decoded <= next;
		end
	end

endmodule

`default_nettype wire

/* execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  logic               clock,
	input  logic               reset,
	rv_pipe_if.execute_mp      ctrl,
	input  rv_pkg::decoded_t   decoded,
	input  rv_pkg::wb_t        wb,
	output rv_pkg::mem_stage_t mem_stage,
	output logic               dmem_read,
	output rv_pkg::word_t      dmem_raddr
);
	import rv_pkg::*;

	word_t op_a;
	word_t op_b;
	word_t alu_b;
	word_t alu_out;
	word_t link_addr;
	logic  taken;

	// memory stage wins over writeback and x0 is never forwarded
	function automatic word_t forward(
		input reg_addr_t  rs,
		input word_t      reg_val,
		input mem_stage_t ms,
		input wb_t        w
	);
		word_t val;
		val = reg_val;
		if (rs != '0) begin
			if (ms.valid && ms.reg_write && !ms.is_load && (ms.rd == rs)) begin
				val = ms.result;
			end else if (w.reg_write && (w.rd == rs)) begin
				val = w.data;
			end
		end
		return val;
	endfunction

	assign op_a = forward(decoded.rs1, decoded.rs1_data, mem_stage, wb);
	assign op_b = forward(decoded.rs2, decoded.rs2_data, mem_stage, wb);
	assign alu_b = decoded.use_imm ? decoded.imm : op_b;

	always_comb begin
		case (decoded.alu_op)
			alu_add: alu_out = op_a + alu_b;
			alu_sub: alu_out = op_a - alu_b;
			alu_and: alu_out = op_a & alu_b;
			alu_or: alu_out = op_a | alu_b;
			alu_xor: alu_out = op_a ^ alu_b;
			alu_slt: alu_out = word_t'($signed(op_a) < $signed(alu_b));
			default: alu_out = op_a + alu_b;
		endcase
	end

	// beq compares the forwarded operands and jal always goes
	assign taken = decoded.valid &&
		((decoded.is_branch && (op_a == op_b)) || decoded.is_jal);

	assign ctrl.redirect = taken;
	assign ctrl.flush = taken;
	assign ctrl.target = decoded.pc + decoded.imm;

	// load address leaves one stage early as rs1 plus imm from the alu
	assign dmem_read = decoded.valid && decoded.is_load;
	assign dmem_raddr = alu_out;

	assign link_addr = decoded.pc + word_t'(4);

	// execute/memory register
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			mem_stage <= '0;
		end else begin
			mem_stage.valid <= decoded.valid;
			mem_stage.result <= (decoded.wb_sel == wb_link) ? link_addr : alu_out;
			mem_stage.store_data <= op_b;
			mem_stage.rd <= decoded.rd;
			mem_stage.is_load <= decoded.is_load;
			mem_stage.is_store <= decoded.is_store;
			mem_stage.reg_write <= decoded.reg_write;
			mem_stage.wb_sel <= decoded.wb_sel;
		end
	end

endmodule

`default_nettype wire

/* mem_wb_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_unit (
	input  logic               clock,
	input  logic               reset,
	input  rv_pkg::mem_stage_t mem_stage,
	input  rv_pkg::word_t      dmem_rdata,
	output logic               dmem_write,
	output rv_pkg::word_t      dmem_waddr,
	output rv_pkg::word_t      dmem_wdata,
	output rv_pkg::wb_t        wb
);
	import rv_pkg::*;

	logic      mw_reg_write;
	reg_addr_t mw_rd;
	wb_sel_t   mw_sel;
	word_t     mw_result;
	word_t     mw_load_data;

	// store goes out during the memory stage
	assign dmem_write = mem_stage.valid && mem_stage.is_store;
	assign dmem_waddr = mem_stage.result;
	assign dmem_wdata = mem_stage.store_data;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			mw_reg_write <= 1'b0;
		end else begin
			mw_reg_write <= mem_stage.valid && mem_stage.reg_write;
		end
	end

	always_ff @(posedge clock) begin
		mw_rd <= mem_stage.rd;
		mw_sel <= mem_stage.wb_sel;
		mw_result <= mem_stage.result;
		mw_load_data <= dmem_rdata;
	end

	// link address already sits in the result field
	always_comb begin
		wb.reg_write = mw_reg_write;
		wb.rd = mw_rd;
		case (mw_sel)
			wb_alu, wb_link: wb.data = mw_result;
			wb_mem: wb.data = mw_load_data;
			default: wb.data = mw_result;
		endcase
	end

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input  logic          clock,
	input  logic          reset,
	output rv_pkg::word_t imem_addr,
	input  rv_pkg::word_t imem_data,
	output logic          dmem_read,
	output rv_pkg::word_t dmem_raddr,
	input  rv_pkg::word_t dmem_rdata,
	output logic          dmem_write,
	output rv_pkg::word_t dmem_waddr,
	output rv_pkg::word_t dmem_wdata
);
	import rv_pkg::*;

	fetch_word_t fetched;
	decoded_t    decoded;
	mem_stage_t  mem_stage;
	wb_t         wb;

	rv_pipe_if ctrl ();

	fetch_unit #(
		.reset_pc(reset_pc)
	) u_fetch (
		.clock     (clock),
		.reset     (reset),
		.ctrl      (ctrl.fetch_mp),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.fetched   (fetched)
	);

	decode_unit u_decode (
		.clock   (clock),
		.reset   (reset),
		.ctrl    (ctrl.decode_mp),
		.fetched (fetched),
		.wb      (wb),
		.decoded (decoded)
	);

	execute_unit u_execute (
		.clock      (clock),
		.reset      (reset),
		.ctrl       (ctrl.execute_mp),
		.decoded    (decoded),
		.wb         (wb),
		.mem_stage  (mem_stage),
		.dmem_read  (dmem_read),
		.dmem_raddr (dmem_raddr)
	);

	mem_wb_unit u_mem_wb (
		.clock      (clock),
		.reset      (reset),
		.mem_stage  (mem_stage),
		.dmem_rdata (dmem_rdata),
		.dmem_write (dmem_write),
		.dmem_waddr (dmem_waddr),
		.dmem_wdata (dmem_wdata),
		.wb         (wb)
	);

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

	localparam logic [31:0] reset_pc = 32'h0000_0000;
	localparam int mem_words = 256;

	logic        clock;
	logic        reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic        dmem_read;
	logic [31:0] dmem_raddr;
	logic [31:0] dmem_rdata;
	logic        dmem_write;
	logic [31:0] dmem_waddr;
	logic [31:0] dmem_wdata;

	logic [31:0] imem [0:mem_words-1];
	logic [31:0] dmem [0:mem_words-1];

	// expected stores in the order the program issues them
	string       exp_name [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];

	int seen;
	int cycles;
	int prog_words;
	int limit;

	rv_core #(
		.reset_pc(reset_pc)
	) dut (
		.clock      (clock),
		.reset      (reset),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_read  (dmem_read),
		.dmem_raddr (dmem_raddr),
		.dmem_rdata (dmem_rdata),
		.dmem_write (dmem_write),
		.dmem_waddr (dmem_waddr),
		.dmem_wdata (dmem_wdata)
	);

	always #2 clock = ~clock;

	task automatic check_value(
		input string       name,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		if (expected !== actual) begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic fill_memories();
		for (int i = 0; i < mem_words; i++) begin
			// spare instruction words end in 00 and match no kept opcode
			imem[i] = 32'h0bad0000 ^ (32'(i) << 2);
			// untouched data words carry their own byte address
			dmem[i] <= 32'hdead0000 ^ (32'(i) << 2);
		end
	endtask

	task automatic load_trace();
		int          fd;
		int          n;
		int          c;
		string       kind;
		string       name;
		logic [31:0] addr;
		logic [31:0] data;
		fd = $fopen("rv_core_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file rv_core_trace.txt");
			$display("Simulation failed");
			$fatal(1);
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, "%s", kind);
				if (n == 1) begin
					if (kind == "i") begin
						n = $fscanf(fd, "%h %h", addr, data);
						imem[addr[9:2]] = data;
						prog_words++;
					end else if (kind == "m") begin
						n = $fscanf(fd, "%h %h", addr, data);
						dmem[addr[9:2]] <= data;
					end else if (kind == "s") begin
						n = $fscanf(fd, "%s %h %h", name, addr, data);
						exp_name.push_back(name);
						exp_addr.push_back(addr);
						exp_data.push_back(data);
					end else if (kind == "#") begin
						// comment runs to end of line
						c = $fgetc(fd);
						while ((c != 10) && (c != -1)) begin
							c = $fgetc(fd);
						end
					end else begin
						$display("trace file holds a line of unknown kind %s", kind);
						$display("Simulation failed");
						$fatal(1);
					end
				end
			end
			$fclose(fd);
			limit = 4 * prog_words + 50;
		end
	endtask

	// memory models answer one edge after the request
	always @(posedge clock) begin
		imem_data <= imem[imem_addr[9:2]];
		if (dmem_read) begin
			dmem_rdata <= dmem[dmem_raddr[9:2]];
		end
		if (dmem_write) begin
			if (!reset) begin
				$display("store to %h happened while reset was asserted", dmem_waddr);
				$display("Simulation failed");
				$fatal(1);
			end else if (seen >= exp_addr.size()) begin
				$display("store of %h to %h came after the last expected store",
					dmem_wdata, dmem_waddr);
				$display("Simulation failed");
				$fatal(1);
			end else begin
				check_value({exp_name[seen], " address"}, exp_addr[seen], dmem_waddr);
				check_value({exp_name[seen], " data"}, exp_data[seen], dmem_wdata);
				dmem[dmem_waddr[9:2]] <= dmem_wdata;
				seen <= seen + 1;
			end
		end
	end

	// run limit scales with the program length
	always @(posedge clock) begin
		if (reset) begin
			if (cycles >= limit) begin
				$display("timeout after %0d cycles with %0d of %0d expected stores seen",
					cycles, seen, exp_addr.size());
				$display("Simulation failed");
				$fatal(1);
			end else begin
				cycles <= cycles + 1;
			end
		end
	end

	initial begin
		clock = 1'b0;
		reset <= 1'b0;
		imem_data <= '0;
		dmem_rdata <= '0;
		seen <= 0;
		cycles <= 0;
		prog_words = 0;
		limit = 0;
		fill_memories();
		load_trace();
		repeat (2) @(posedge clock);
		// still in reset, so the first request must be at reset_pc
		check_value("reset_pc", reset_pc, imem_addr);
		reset <= 1'b1;
		while (seen < exp_addr.size()) begin
			@(posedge clock);
		end
		// later stores are caught by the memory model while the final jal spins
		repeat (10) @(posedge clock);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* rv_core_trace.txt */
# i <byte address> <instruction> and m <byte address> <data word>
# s <test name> <store address> <store data>, in the order the stores happen
i 00000000 00c00093 # addi x1, x0, 12
i 00000004 ffb00113 # addi x2, x0, -5
i 00000008 002081b3 # add  x3, x1, x2
i 0000000c 40208233 # sub  x4, x1, x2
i 00000010 0020f2b3 # and  x5, x1, x2
i 00000014 0020e333 # or   x6, x1, x2
i 00000018 0020c3b3 # xor  x7, x1, x2
i 0000001c 00112433 # slt  x8, x2, x1
i 00000020 0020a4b3 # slt  x9, x1, x2
i 00000024 10302023 # sw   x3, 0x100(x0)
i 00000028 10402223 # sw   x4, 0x104(x0)
i 0000002c 10502423 # sw   x5, 0x108(x0)
i 00000030 10602623 # sw   x6, 0x10c(x0)
i 00000034 10702823 # sw   x7, 0x110(x0)
i 00000038 10802a23 # sw   x8, 0x114(x0)
i 0000003c 10902c23 # sw   x9, 0x118(x0)
i 00000040 10202e23 # sw   x2, 0x11c(x0)
i 00000044 00300513 # addi x10, x0, 3
i 00000048 00a505b3 # add  x11, x10, x10
i 0000004c 00a58633 # add  x12, x11, x10
i 00000050 40b606b3 # sub  x13, x12, x11
i 00000054 12d02023 # sw   x13, 0x120(x0)
i 00000058 12c02223 # sw   x12, 0x124(x0)
i 0000005c 20002703 # lw   x14, 0x200(x0)
i 00000060 00a707b3 # add  x15, x14, x10
i 00000064 12f02423 # sw   x15, 0x128(x0)
i 00000068 20402803 # lw   x16, 0x204(x0)
i 0000006c 13002623 # sw   x16, 0x12c(x0)
i 00000070 00d50663 # beq  x10, x13, +12 taken
i 00000074 12102823 # sw   x1, 0x130(x0) skipped
i 00000078 12102a23 # sw   x1, 0x134(x0) skipped
i 0000007c 00b50463 # beq  x10, x11, +8 not taken
i 00000080 12b02c23 # sw   x11, 0x138(x0)
i 00000084 00c008ef # jal  x17, +12
i 00000088 12102e23 # sw   x1, 0x13c(x0) skipped
i 0000008c 14102023 # sw   x1, 0x140(x0) skipped
i 00000090 15102223 # sw   x17, 0x144(x0)
i 00000094 03700013 # addi x0, x0, 55
i 00000098 14002423 # sw   x0, 0x148(x0)
i 0000009c 0000006f # jal  x0, 0
m 00000200 00001000
m 00000204 7ffffff0
s alu_add        00000100 00000007
s alu_sub        00000104 00000011
s alu_and        00000108 00000008
s alu_or         0000010c ffffffff
s alu_xor        00000110 fffffff7
s alu_slt_neg    00000114 00000001
s alu_slt_pos    00000118 00000000
s addi_neg       0000011c fffffffb
s fwd_chain      00000120 00000003
s fwd_write_thru 00000124 00000009
s load_use       00000128 00001003
s load_store     0000012c 7ffffff0
s beq_not_taken  00000138 00000006
s jal_link       00000144 00000088
s x0_discard     00000148 00000000

/* filelist.f */
rv_pkg.sv
rv_pipe_if.sv
fetch_unit.sv
reg_file.sv
decode_unit.sv
execute_unit.sv
mem_wb_unit.sv
rv_core.sv
tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_rv_core -o tb_sim

result=$(./obj_dir/tb_sim 2>&1) || true
echo "$result"

if grep -qx "Simulation completed successfully" <<< "$result"; then
	exit 0
fi
exit 1
